/* Makefile */
# Verilator build and run for the EEPROM controller testbench
# any variable can be overridden, e.g. make run LOG=other.log

VERILATOR ?= verilator
TOP       ?= tb_eeprom_ctrl
FLIST     ?= eeprom_ctrl.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
SEED_ARGS ?= +verilator+seed+1
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0

SOURCES := $(FLIST) $(wildcard verilog/*.sv verilog/*.svh test/*.sv)

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)

# the log decides pass or fail, grep returns non-zero when the pass line is missing
run: compile
	./$(OBJ_DIR)/V$(TOP) $(SEED_ARGS) > $(LOG) 2>&1; cat $(LOG)
	grep -q "^test passed$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* eeprom_ctrl.f */
+incdir+verilog
verilog/i2c_pkg.sv
verilog/eeprom_pkg.sv
verilog/eeprom_req_latch.sv
verilog/eeprom_seq.sv
verilog/i2c_byte_engine.sv
verilog/eeprom_ctrl.sv
test/tb_clk_gen.sv
test/eeprom_model.sv
test/tb_eeprom_ctrl.sv

/* test/eeprom_model.sv */
`timescale 1ns/1ps
`default_nettype none
`include "eeprom_cfg.svh"

// behavioural 24C16 slave, bus oversampled on the falling CLK edge
module eeprom_model
(
    input  wire clk,
    input  wire scl,
    inout  wire sda,
    input  wire refuse      // nack every control byte
);
    typedef enum logic [2:0] {
        M_IDLE,
        M_RX,
        M_ACK,
        M_TX,
        M_MACK
    } model_state_e;

    logic [`EEPROM_DATA_W-1:0] mem [0:(1 << `EEPROM_ADDR_W)-1];
    model_state_e mstate;
    logic scl_q;
    logic sda_q;
    logic scl_s;
    logic sda_s;
    logic drive_low;
    logic ack;
    logic [3:0] bitcnt;
    logic [7:0] shreg;
    logic [1:0] byte_idx;
    logic rw;
    logic [2:0] blk;
    logic [7:0] word;
    logic [7:0] wr_data;
    logic wr_pending;   // committed at stop

    pullup (sda);
    assign sda = drive_low ? 1'b0 : 1'bz;

    initial
    begin
        for (int a = 0; a < (1 << `EEPROM_ADDR_W); a++)
            mem[a[10:0]] = a[7:0] ^ {5'b0, a[10:8]};
        mstate     = M_IDLE;
        drive_low  = 1'b0;
        scl_q      = 1'b1;
        sda_q      = 1'b1;
        bitcnt     = 4'd0;
        byte_idx   = 2'd0;
        rw         = 1'b0;
        wr_pending = 1'b0;
    end

    always @(negedge clk)
    begin
        scl_s = (scl !== 1'b0);
        sda_s = (sda !== 1'b0);
        if (scl_q && scl_s && sda_q && !sda_s)
        begin
            mstate     = M_RX;  // start or repeated start
            bitcnt     = 4'd0;
            byte_idx   = 2'd0;
            wr_pending = 1'b0;
            drive_low  = 1'b0;
        end
        else if (scl_q && scl_s && !sda_q && sda_s)
        begin
            if (wr_pending)
                mem[{blk, word}] = wr_data;
            wr_pending = 1'b0;
            mstate     = M_IDLE;
            drive_low  = 1'b0;
        end
        else if (!scl_q && scl_s && mstate == M_RX)
        begin
            shreg  = {shreg[6:0], sda_s};
            bitcnt = bitcnt + 4'd1;
        end
        else if (scl_q && !scl_s)
        begin
            case (mstate)
                M_RX:
                    if (bitcnt == 4'd8)
                    begin
                        ack = 1'b1;
                        if (byte_idx == 2'd0)
                        begin
                            ack = (shreg[7:4] == `EEPROM_DEV_CODE) && !refuse;
                            blk = shreg[3:1];
                            rw  = shreg[0];
                        end
                        else if (byte_idx == 2'd1)
                            word = shreg;
                        else
                        begin
                            wr_data    = shreg;
                            wr_pending = 1'b1;
                        end
                        drive_low = ack;
                        mstate    = ack ? M_ACK : M_IDLE;
                    end
                M_ACK:
                begin
                    byte_idx = byte_idx + 2'd1;
                    if (rw)
                    begin
                        shreg     = mem[{blk, word}];
                        drive_low = !shreg[7];  // msb right after the ack clock
                        bitcnt    = 4'd1;
                        mstate    = M_TX;
                    end
                    else
                    begin
                        drive_low = 1'b0;
                        bitcnt    = 4'd0;
                        mstate    = M_RX;
                    end
                end
                M_TX:
                    if (bitcnt == 4'd8)
                    begin
                        drive_low = 1'b0;   // let the master answer
                        mstate    = M_MACK;
                    end
                    else
                    begin
                        shreg     = {shreg[6:0], 1'b0};
                        drive_low = !shreg[7];
                        bitcnt    = bitcnt + 4'd1;
                    end
                M_MACK:
                    mstate = M_IDLE;    // no sequential reads
                default: ;
            endcase
        end
        scl_q = scl_s;
        sda_q = sda_s;
    end

endmodule

`default_nettype wire

/* test/tb_clk_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen
(
    output logic clk
);
    localparam int HALF_PERIOD = 5;   // 10 ns period

    initial
        clk = 1'b0;

    always #HALF_PERIOD clk = ~clk;

endmodule

`default_nettype wire

/* test/tb_eeprom_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none
`include "eeprom_cfg.svh"

module tb_eeprom_ctrl;

    localparam logic [31:0] SEED = 32'hbf879423;
    localparam int RANDOM_TXN   = 40;
    localparam int TXN_TOTAL    = 64;
    localparam int RESET_CYCLES = 16;
    // 2 starts, 4 bytes, 1 stop plus command turnaround
    localparam int READ_CYCLES  = 39 * 4 * `EEPROM_SCL_QTR + 32;
    localparam int WATCHDOG_CYCLES = TXN_TOTAL * READ_CYCLES * 2;

    typedef struct packed {
        logic                      is_read;
        logic                      nack;
        logic [`EEPROM_ADDR_W-1:0] addr;
        logic [`EEPROM_DATA_W-1:0] data;
    } txn_t;

    logic CLK;
    logic RESET;
    logic wr;
    logic rd;
    logic refuse;
    logic [`EEPROM_ADDR_W-1:0] addr;
    logic [`EEPROM_DATA_W-1:0] wdata;
    logic [`EEPROM_DATA_W-1:0] rdata;
    logic ack;
    logic nack_err;
    logic scl;
    wire sda;

    txn_t exp_q[$];     // accepted requests waiting for their ACK
    logic [`EEPROM_DATA_W-1:0] shadow [0:(1 << `EEPROM_ADDR_W)-1];
    logic written [0:(1 << `EEPROM_ADDR_W)-1];
    int err_count;
    int ack_count;
    int tests_ok;
    int tests_bad;
    int test_base;
    string test_name;

    tb_clk_gen u_clk (
        .clk (CLK)
    );

    eeprom_ctrl u_dut (
        .CLK      (CLK),
        .RESET    (RESET),
        .WR       (wr),
        .RD       (rd),
        .ADDR     (addr),
        .WDATA    (wdata),
        .RDATA    (rdata),
        .ACK      (ack),
        .NACK_ERR (nack_err),
        .SCL      (scl),
        .SDA      (sda)
    );

    eeprom_model u_eeprom (
        .clk    (CLK),
        .scl    (scl),
        .sda    (sda),
        .refuse (refuse)
    );

    // unwritten bytes hold the low address byte xor the block number
    function automatic logic [7:0] expected_byte(input logic [`EEPROM_ADDR_W-1:0] a);
        if (written[a])
            return shadow[a];
        return a[7:0] ^ {5'b0, a[10:8]};
    endfunction

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp)
        begin
            $display("error %s: got 0x%0h, expected 0x%0h", name, got, exp);
            err_count++;
        end
    endtask

    task automatic start_test(input string name);
        test_name = name;
        test_base = err_count;
    endtask

    task automatic close_test;
        if (err_count == test_base)
        begin
            tests_ok++;
            $display("[ok]   %s", test_name);
        end
        else
        begin
            tests_bad++;
            $display("[FAIL] %s, %0d errors", test_name, err_count - test_base);
        end
    endtask

    task automatic drive_strobe(input logic is_read, input logic [`EEPROM_ADDR_W-1:0] a,
                                input logic [`EEPROM_DATA_W-1:0] d);
        @(negedge CLK);
        wr    = !is_read;
        rd    = is_read;
        addr  = a;
        wdata = d;
        @(negedge CLK);
        wr = 1'b0;
        rd = 1'b0;
    endtask

    // one request, then wait for its ACK
    task automatic transfer(input logic is_read, input logic [`EEPROM_ADDR_W-1:0] a,
                            input logic [`EEPROM_DATA_W-1:0] d, input logic nack);
        txn_t t;
        int start_cnt;
        int n;
        t.is_read = is_read;
        t.nack    = nack;
        t.addr    = a;
        t.data    = d;
        start_cnt = ack_count;
        exp_q.push_back(t);
        drive_strobe(is_read, a, d);
        n = 0;
        while (ack_count == start_cnt && n < READ_CYCLES * 2)
        begin
            @(negedge CLK);
            n++;
        end
        if (ack_count == start_cnt)
        begin
            $display("no ACK within %0d cycles after the request to 0x%0h", n, a);
            err_count++;
        end
    endtask

    task automatic compare_acks;
        txn_t t;
        forever
        begin
            @(negedge CLK);
            if (!RESET && ack)
            begin
                ack_count++;
                if (exp_q.size() == 0)
                begin
                    $display("ACK pulse arrived with no request outstanding");
                    err_count++;
                end
                else
                begin
                    t = exp_q.pop_front();
                    check("NACK_ERR", 32'(nack_err), 32'(t.nack));
                    if (t.is_read && !t.nack)
                        check("RDATA", 32'(rdata), 32'(expected_byte(t.addr)));
                    else if (!t.is_read && !t.nack)
                    begin
                        shadow[t.addr]  = t.data;
                        written[t.addr] = 1'b1;
                    end
                end
            end
        end
    endtask

    initial
    begin
        repeat (WATCHDOG_CYCLES + RESET_CYCLES) @(posedge CLK);
        $display("watchdog: no end of run after %0d cycles", WATCHDOG_CYCLES + RESET_CYCLES);
        $display("test failed");
        $finish;
    end

    initial
    begin
        int i;
        int accepted;
        logic [31:0] rnd;
        logic [`EEPROM_ADDR_W-1:0] a;
        RESET     = 1'b1;
        wr        = 1'b0;
        rd        = 1'b0;
        addr      = '0;
        wdata     = '0;
        refuse    = 1'b0;
        err_count = 0;
        ack_count = 0;
        tests_ok  = 0;
        tests_bad = 0;
        for (i = 0; i < (1 << `EEPROM_ADDR_W); i++)
            written[i[10:0]] = 1'b0;
        void'($urandom(SEED));
        fork
            compare_acks();
        join_none
        repeat (RESET_CYCLES) @(negedge CLK);
        RESET = 1'b0;

        start_test("outputs after reset");
        check("ACK", 32'(ack), 32'd0);
        check("NACK_ERR", 32'(nack_err), 32'd0);
        check("SCL", 32'(scl), 32'd1);
        check("SDA", 32'(sda), 32'd1);
        check("RDATA", 32'(rdata), 32'd0);
        close_test();

        start_test("write then read back");
        transfer(1'b0, 11'h123, 8'h5e, 1'b0);
        transfer(1'b1, 11'h123, 8'h00, 1'b0);
        transfer(1'b0, 11'h7ff, 8'ha1, 1'b0);
        transfer(1'b1, 11'h7ff, 8'h00, 1'b0);
        close_test();

        start_test("unwritten address in each block");
        for (i = 0; i < 8; i++)
            transfer(1'b1, {i[2:0], 8'hc3}, 8'h00, 1'b0);
        close_test();

        start_test("random writes and reads");
        for (i = 0; i < RANDOM_TXN; i++)
        begin
            rnd = $urandom();
            a   = {rnd[10:8], 5'b0, rnd[2:0]};  // small window so reads hit writes
            transfer(rnd[31], a, rnd[23:16], 1'b0);
        end
        close_test();

        start_test("strobes during a transaction");
        accepted = ack_count + 1;
        fork
            transfer(1'b0, 11'h2a5, 8'h3c, 1'b0);
            begin
                repeat (16 * `EEPROM_SCL_QTR) @(negedge CLK);
                drive_strobe(1'b0, 11'h2a6, 8'hee);
                repeat (32 * `EEPROM_SCL_QTR) @(negedge CLK);
                drive_strobe(1'b1, 11'h2a6, 8'h00);
            end
        join
        repeat (READ_CYCLES) @(negedge CLK);
        check("ack_count", 32'(ack_count), 32'(accepted));
        transfer(1'b1, 11'h2a6, 8'h00, 1'b0);
        transfer(1'b1, 11'h2a5, 8'h00, 1'b0);
        close_test();

        start_test("refused transactions");
        refuse = 1'b1;
        transfer(1'b0, 11'h123, 8'h99, 1'b1);
        transfer(1'b1, 11'h400, 8'h00, 1'b1);
        refuse = 1'b0;
        transfer(1'b1, 11'h123, 8'h00, 1'b0);
        close_test();

        $display("tests: %0d ok, %0d failing, %0d check errors, %0d ACK pulses",
                 tests_ok, tests_bad, err_count, ack_count);
        if (err_count == 0)
            $display("test passed");
        else
            $display("test failed");
        $finish;
    end

endmodule

`default_nettype wire

/* verilog/eeprom_cfg.svh */
`ifndef EEPROM_CFG_SVH
`define EEPROM_CFG_SVH

// 24C16: 2048 bytes, block bits ride in the control byte
`define EEPROM_ADDR_W 11
`define EEPROM_DATA_W 8

`define EEPROM_DEV_CODE 4'b1010

// CLK cycles per quarter of an SCL period, 1 or more
`define EEPROM_SCL_QTR 2

`endif

/* verilog/eeprom_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none
`include "eeprom_cfg.svh"

module eeprom_ctrl
(
    input  wire                          CLK,
    input  wire                          RESET,
    input  wire                          WR,
    input  wire                          RD,
    input  wire [`EEPROM_ADDR_W-1:0]     ADDR,
    input  wire [`EEPROM_DATA_W-1:0]     WDATA,
    output logic [`EEPROM_DATA_W-1:0]    RDATA,
    output logic                         ACK,
    output logic                         NACK_ERR,
    output logic                         SCL,
    inout  wire                          SDA
);
    import i2c_pkg::*;
    import eeprom_pkg::*;

    logic req_pending;
    op_e req_op;
    logic [`EEPROM_ADDR_W-1:0] req_addr;
    logic [`EEPROM_DATA_W-1:0] req_wdata;
    logic req_take;
    logic done_pulse;
    logic cmd_go;
    byte_cmd_e cmd;
    logic [`EEPROM_DATA_W-1:0] tx_byte;
    logic eng_busy;
    logic cmd_done;
    logic [`EEPROM_DATA_W-1:0] rx_byte;
    logic slave_ack;
    logic sda_oe;

    // open drain, pull-up sits on the board
    assign SDA = sda_oe ? 1'b0 : 1'bz;

    eeprom_req_latch u_latch (
        .CLK         (CLK),
        .RESET       (RESET),
        .WR          (WR),
        .RD          (RD),
        .ADDR        (ADDR),
        .WDATA       (WDATA),
        .req_take    (req_take),
        .done_pulse  (done_pulse),
        .req_pending (req_pending),
        .req_op      (req_op),
        .req_addr    (req_addr),
        .req_wdata   (req_wdata)
    );

    eeprom_seq u_seq (
        .CLK         (CLK),
        .RESET       (RESET),
        .req_pending (req_pending),
        .req_op      (req_op),
        .req_addr    (req_addr),
        .req_wdata   (req_wdata),
        .req_take    (req_take),
        .done_pulse  (done_pulse),
        .cmd_go      (cmd_go),
        .cmd         (cmd),
        .tx_byte     (tx_byte),
        .eng_busy    (eng_busy),
        .cmd_done    (cmd_done),
        .rx_byte     (rx_byte),
        .slave_ack   (slave_ack),
        .ACK         (ACK),
        .NACK_ERR    (NACK_ERR),
        .RDATA       (RDATA)
    );

    i2c_byte_engine u_engine (
        .CLK       (CLK),
        .RESET     (RESET),
        .cmd_go    (cmd_go),
        .cmd       (cmd),
        .tx_byte   (tx_byte),
        .sda_in    (SDA),
        .eng_busy  (eng_busy),
        .cmd_done  (cmd_done),
        .rx_byte   (rx_byte),
        .slave_ack (slave_ack),
        .scl       (SCL),
        .sda_oe    (sda_oe)
    );

endmodule

`default_nettype wire

/* verilog/eeprom_pkg.sv */
`default_nettype none

package eeprom_pkg;

    typedef enum logic [0:0] {
        OP_WRITE,
        OP_READ
    } op_e;

    // one engine command per state, except idle and done
    typedef enum logic [3:0] {
        S_IDLE,
        S_START,
        S_CTRL_W,
        S_ADDR,
        S_DATA_W,
        S_RESTART,  // repeated start before the read control byte
        S_CTRL_R,
        S_DATA_R,
        S_STOP,
        S_DONE
    } seq_state_e;

endpackage

`default_nettype wire

/* verilog/eeprom_req_latch.sv */
`timescale 1ns/1ps
`default_nettype none
`include "eeprom_cfg.svh"

module eeprom_req_latch
(
    input  wire                          CLK,
    input  wire                          RESET,
    input  wire                          WR,
    input  wire                          RD,
    input  wire [`EEPROM_ADDR_W-1:0]     ADDR,
    input  wire [`EEPROM_DATA_W-1:0]     WDATA,
    input  wire                          req_take,
    input  wire                          done_pulse,
    output logic                         req_pending,
    output eeprom_pkg::op_e              req_op,
    output logic [`EEPROM_ADDR_W-1:0]    req_addr,
    output logic [`EEPROM_DATA_W-1:0]    req_wdata
);
    import eeprom_pkg::*;

    logic busy;     // from accepted strobe until done_pulse
    logic accept;

    assign accept = !busy && (WR || RD);

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            busy        <= 1'b0;
            req_pending <= 1'b0;
        end
        else if (accept)
        begin
            busy        <= 1'b1;
            req_pending <= 1'b1;
        end
        else
        begin
            if (req_take)
                req_pending <= 1'b0;
            if (done_pulse)
                busy <= 1'b0;
        end
    end

    always_ff @(posedge CLK)
    begin
        if (accept)
        begin
            req_op    <= WR ? OP_WRITE : OP_READ;   // WR wins
            req_addr  <= ADDR;
            req_wdata <= WDATA;
        end
    end

    a_take_pending: assert property (@(posedge CLK) disable iff (RESET)
        req_take |-> req_pending)
        else $error("req_take without a pending request");

endmodule

`default_nettype wire

/* verilog/eeprom_seq.sv */
`timescale 1ns/1ps
`default_nettype none
`include "eeprom_cfg.svh"

module eeprom_seq
(
    input  wire                          CLK,
    input  wire                          RESET,
    input  wire                          req_pending,
    input  wire eeprom_pkg::op_e         req_op,
    input  wire [`EEPROM_ADDR_W-1:0]     req_addr,
    input  wire [`EEPROM_DATA_W-1:0]     req_wdata,
    output logic                         req_take,
    output logic                         done_pulse,
    output logic                         cmd_go,
    output i2c_pkg::byte_cmd_e           cmd,
    output logic [`EEPROM_DATA_W-1:0]    tx_byte,
    input  wire                          eng_busy,
    input  wire                          cmd_done,
    input  wire [`EEPROM_DATA_W-1:0]     rx_byte,
    input  wire                          slave_ack,
    output logic                         ACK,
    output logic                         NACK_ERR,
    output logic [`EEPROM_DATA_W-1:0]    RDATA
);
    import i2c_pkg::*;
    import eeprom_pkg::*;

    seq_state_e state;
    logic issued;   // command of this state already handed to the engine
    logic abort;
    logic [`EEPROM_DATA_W-1:0] ctrl_w;
    logic [`EEPROM_DATA_W-1:0] ctrl_r;

    // device code, block bits, r/w bit
    assign ctrl_w = {`EEPROM_DEV_CODE, req_addr[`EEPROM_ADDR_W-1:8], 1'b0};
    assign ctrl_r = {`EEPROM_DEV_CODE, req_addr[`EEPROM_ADDR_W-1:8], 1'b1};

    assign req_take   = (state == S_IDLE) && req_pending;
    assign done_pulse = (state == S_DONE);
    assign cmd_go     = (state != S_IDLE) && (state != S_DONE) && !issued && !eng_busy;

    always_comb
    begin
        cmd     = CMD_WRITE;
        tx_byte = req_addr[7:0];
        case (state)
            S_START, S_RESTART: cmd = CMD_START;
            S_CTRL_W:           tx_byte = ctrl_w;
            S_DATA_W:           tx_byte = req_wdata;
            S_CTRL_R:           tx_byte = ctrl_r;
            S_DATA_R:           cmd = CMD_READ;
            S_IDLE, S_STOP, S_DONE: cmd = CMD_STOP;
            default: ;
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state    <= S_IDLE;
            issued   <= 1'b0;
            abort    <= 1'b0;
            ACK      <= 1'b0;
            NACK_ERR <= 1'b0;
            RDATA    <= '0;
        end
        else
        begin
            ACK <= 1'b0;
            if (cmd_go)
                issued <= 1'b1;
            if (cmd_done)
                issued <= 1'b0;
            case (state)
                S_IDLE:
                    if (req_pending)
                    begin
                        abort <= 1'b0;
                        state <= S_START;
                    end
                S_START:
                    if (cmd_done)
                        state <= S_CTRL_W;
                S_CTRL_W, S_ADDR, S_DATA_W, S_CTRL_R:
                    if (cmd_done)
                    begin
                        if (!slave_ack)
                        begin
                            abort <= 1'b1;  // slave refused, close the bus
                            state <= S_STOP;
                        end
                        else if (state == S_CTRL_W)
                            state <= S_ADDR;
                        else if (state == S_ADDR)
                            state <= (req_op == OP_WRITE) ? S_DATA_W : S_RESTART;
                        else if (state == S_CTRL_R)
                            state <= S_DATA_R;
                        else
                            state <= S_STOP;
                    end
                S_RESTART:
                    if (cmd_done)
                        state <= S_CTRL_R;
                S_DATA_R:
                    if (cmd_done)
                        state <= S_STOP;
                S_STOP:
                    if (cmd_done)
                    begin
                        ACK      <= 1'b1;
                        NACK_ERR <= abort;
                        if (req_op == OP_READ && !abort)
                            RDATA <= rx_byte;   // engine holds it since the read
                        state    <= S_DONE;
                    end
                default:
                    state <= S_IDLE;
            endcase
        end
    end

    a_ack_single: assert property (@(posedge CLK) disable iff (RESET)
        ACK |=> !ACK)
        else $error("ACK high for two cycles");

endmodule

`default_nettype wire

/* verilog/i2c_byte_engine.sv */
`timescale 1ns/1ps
`default_nettype none
`include "eeprom_cfg.svh"

module i2c_byte_engine
(
    input  wire                          CLK,
    input  wire                          RESET,
    input  wire                          cmd_go,
    input  wire i2c_pkg::byte_cmd_e      cmd,
    input  wire [`EEPROM_DATA_W-1:0]     tx_byte,
    input  wire                          sda_in,
    output logic                         eng_busy,
    output logic                         cmd_done,
    output logic [`EEPROM_DATA_W-1:0]    rx_byte,
    output logic                         slave_ack,
    output logic                         scl,
    output logic                         sda_oe
);
    import i2c_pkg::*;

    localparam int qtr = `EEPROM_SCL_QTR;
    localparam int qw  = (qtr > 1) ? $clog2(qtr) : 1;

    bit_phase_e phase;
    logic [qw-1:0] qcnt;
    logic [1:0] quarter;
    logic [2:0] bitcnt;
    logic [`EEPROM_DATA_W-1:0] shreg;
    logic is_read;
    logic q_end;
    logic period_end;
    logic sample;
    logic scl_nx;
    logic sda_nx;

    assign eng_busy   = (phase != PH_IDLE);
    assign q_end      = (qcnt == qw'(qtr - 1));
    assign period_end = eng_busy && q_end && (quarter == 2'd3);
    assign sample     = eng_busy && q_end && (quarter == 2'd2);  // scl is high here

    // bus levels per quarter, seen one cycle later on the pins
    always_comb
    begin
        scl_nx = scl;
        sda_nx = sda_oe;
        case (phase)
            PH_START:
            begin
                scl_nx = (quarter != 2'd3);
                sda_nx = quarter[1];    // sda falls with scl high
            end
            PH_STOP:
            begin
                scl_nx = (quarter != 2'd0);
                sda_nx = !quarter[1];   // sda rises with scl high
            end
            PH_BIT:
            begin
                scl_nx = quarter[0] ^ quarter[1];
                sda_nx = !is_read && !shreg[`EEPROM_DATA_W-1];
            end
            PH_ACK:
            begin
                scl_nx = quarter[0] ^ quarter[1];
                sda_nx = 1'b0;          // slave ack, or master nack on reads
            end
            default: ;
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            phase    <= PH_IDLE;
            qcnt     <= '0;
            quarter  <= 2'd0;
            cmd_done <= 1'b0;
            scl      <= 1'b1;
            sda_oe   <= 1'b0;
        end
        else
        begin
            cmd_done <= 1'b0;
            scl      <= scl_nx;
            sda_oe   <= sda_nx;
            if (cmd_go)
            begin
                qcnt    <= '0;
                quarter <= 2'd0;
                case (cmd)
                    CMD_START: phase <= PH_START;
                    CMD_STOP:  phase <= PH_STOP;
                    default:   phase <= PH_BIT;
                endcase
            end
            else if (eng_busy)
            begin
                qcnt <= q_end ? '0 : qcnt + 1'b1;
                if (q_end)
                    quarter <= quarter + 2'd1;
                if (period_end)
                begin
                    if (phase == PH_BIT)
                    begin
                        if (bitcnt == 3'd0)
                            phase <= PH_ACK;
                    end
                    else
                    begin
                        phase    <= PH_IDLE;
                        cmd_done <= 1'b1;
                    end
                end
            end
        end
    end

    always_ff @(posedge CLK)
    begin
        if (cmd_go)
        begin
            bitcnt  <= 3'd7;
            is_read <= (cmd == CMD_READ);
            shreg   <= tx_byte;
        end
        else if (phase == PH_BIT)
        begin
            if (sample && is_read)
                shreg <= {shreg[`EEPROM_DATA_W-2:0], sda_in};  // msb first
            if (period_end)
            begin
                bitcnt <= bitcnt - 3'd1;
                if (!is_read)
                    shreg <= {shreg[`EEPROM_DATA_W-2:0], 1'b0};
            end
        end
        else if (phase == PH_ACK)
        begin
            if (sample && !is_read)
                slave_ack <= !sda_in;
            if (period_end && is_read)
                rx_byte <= shreg;
        end
    end

    a_go_idle: assert property (@(posedge CLK) disable iff (RESET)
        !(cmd_go && eng_busy))
        else $error("cmd_go while engine busy");

endmodule

`default_nettype wire

/* verilog/i2c_pkg.sv */
`default_nettype none

package i2c_pkg;

    // byte-level commands from the sequencer
    typedef enum logic [1:0] {
        CMD_START,
        CMD_STOP,
        CMD_WRITE,
        CMD_READ
    } byte_cmd_e;

    typedef enum logic [2:0] {
        PH_IDLE,
        PH_START,
        PH_BIT,   // eight data bits
        PH_ACK,   // ninth bit
        PH_STOP
    } bit_phase_e;

endpackage

`default_nettype wire
